// File: aggre_cfg_pkg.sv
package aggre_cfg_pkg;

    // Pipe count is fixed, the order rotation is written for four
    localparam int NUM_PIPES  = 4;
    localparam int PIPE_IDX_W = 2;

    localparam int DT_WIDTH_DEF = 6; // Video data type width

    // Aggregation mode select
    typedef enum logic [1:0] {
        AGGRE_NONE   = 2'd0,
        AGGRE_CONCAT = 2'd1, // Line interleaved concatenation
        AGGRE_RSVD2  = 2'd2,
        AGGRE_RSVD3  = 2'd3
    } aggre_mode_t;

    // Per pipe write mode
    typedef enum logic [1:0] {
        WR_MASKED = 2'd0, // Pipe masked after video loss or force mask
        WR_CONCAT = 2'd2,
        WR_IDLE   = 2'd3
    } wr_mode_t;

endpackage

// File: aggre_sch_pkg.sv
package aggre_sch_pkg;

    // Configuration FSM
    typedef enum logic [2:0] {
        INIT         = 3'd0,
        IDLE         = 3'd1,
        START_SCH    = 3'd2,
        WAIT_END_SCH = 3'd3,
        CFG_UPDATE   = 3'd4,
        PIPE_CLEAR   = 3'd5
    } concat_state_t;

    // Line scheduler FSM
    typedef enum logic [2:0] {
        SILENT          = 3'd0,
        START_CONCAT    = 3'd1,
        MASTER          = 3'd2,
        ORDER           = 3'd3,
        WAIT_ACK        = 3'd4,
        CLEAR_STATE     = 3'd5,
        WAIT_LINE_END   = 3'd6,
        END_CONCAT      = 3'd7
    } sch_state_t;

endpackage

// File: data_type_compare.sv
`timescale 1ns/1ns

module data_type_compare
    import aggre_cfg_pkg::*;
#(
    parameter int DT_WIDTH = DT_WIDTH_DEF
) (
    input  logic [NUM_PIPES-1:0]               dt_vld,
    input  logic [NUM_PIPES-1:0][DT_WIDTH-1:0] dt,
    output logic                               dt_fail
);

    // Any two valid inputs carrying different types fail the check
    // Zero or one valid input never fails
    always_comb begin
        dt_fail = 1'b0;
        for (int i = 0; i < NUM_PIPES - 1; i++) begin
            for (int j = i + 1; j < NUM_PIPES; j++) begin
                if (dt_vld[i] && dt_vld[j] && (dt[i] != dt[j])) begin
                    dt_fail = 1'b1;
                end
            end
        end
    end

endmodule

// File: concat_cfg_ctrl.sv
`timescale 1ns/1ns

module concat_cfg_ctrl
    import aggre_cfg_pkg::*;
    import aggre_sch_pkg::*;
#(
    parameter int DT_WIDTH = DT_WIDTH_DEF
) (
    input  logic                               aggre_clk,
    input  logic                               aggre_clk_rst_n,
    input  aggre_mode_t                        aggre_mode,
    input  logic [NUM_PIPES-1:0]               concat_en,
    input  logic [NUM_PIPES-1:0]               video_loss,
    input  logic [NUM_PIPES-1:0]               empty,
    input  logic                               frame_sync_lock,
    input  logic [NUM_PIPES-1:0]               auto_mask_en,
    input  logic [NUM_PIPES-1:0]               force_video_mask,
    input  logic [NUM_PIPES-1:0]               video_mask_restart,
    input  logic [NUM_PIPES-1:0]               dt_vld,
    input  logic [NUM_PIPES-1:0][DT_WIDTH-1:0] dt,
    input  logic                               sch_end,
    output wr_mode_t [NUM_PIPES-1:0]           wr_mode,
    output logic [NUM_PIPES-1:0]               wr_mode_strobe,
    output logic [NUM_PIPES-1:0]               pipe_clear_bit_map,
    output logic                               sch_data_type_align_fail_int,
    output logic                               sch_start,
    output logic [NUM_PIPES-1:0]               pipe_rdy
);

    concat_state_t        cs;
    concat_state_t        ns;
    logic                 concat_mode;
    logic [NUM_PIPES-1:0] mode_mask;    // concat_mode replicated per pipe
    logic [NUM_PIPES-1:0] auto_en;
    logic [NUM_PIPES-1:0] loss_map;
    logic [NUM_PIPES-1:0] recover_map;
    logic                 pipe_quit;
    logic                 pipe_recover;
    logic                 pipe_qualify;
    logic [NUM_PIPES-1:0] mask_map;
    logic                 start_cond;
    logic [NUM_PIPES-1:0] cmp_vld;
    logic                 dt_fail;

    assign concat_mode = (aggre_mode == AGGRE_CONCAT);
    assign mode_mask   = {NUM_PIPES{concat_mode}};
    assign auto_en     = concat_en & auto_mask_en;

    assign loss_map     = video_loss & auto_en & mode_mask;
    assign pipe_quit    = |loss_map;
    assign recover_map  = concat_en & video_mask_restart & auto_en & mode_mask & mask_map;
    assign pipe_recover = |recover_map;

    assign pipe_rdy = ~empty & concat_en & mode_mask;

    // Every enabled pipe either has data or is masked
    assign pipe_qualify = ((concat_en & (pipe_rdy | mask_map)) == concat_en);

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            cs <= INIT;
        end else begin
            cs <= ns;
        end
    end

    always_comb begin
        ns = cs;
        case (cs)
            INIT: begin
                if (concat_mode && frame_sync_lock) ns = CFG_UPDATE;
            end
            IDLE: begin
                if (pipe_quit || pipe_recover) begin
                    ns = CFG_UPDATE;
                end else if (pipe_qualify) begin
                    ns = START_SCH;
                end
            end
            START_SCH:    ns = WAIT_END_SCH;
            WAIT_END_SCH: begin
                if (sch_end) ns = IDLE; // Never comes after an aligned-type failure
            end
            CFG_UPDATE:   ns = PIPE_CLEAR;
            PIPE_CLEAR:   ns = IDLE;
            default:      ns = INIT;
        endcase
    end

    // Mask bitmap, force mask seeds it on lock
    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            mask_map <= '0;
        end else if (cs == INIT && ns == CFG_UPDATE) begin
            mask_map <= concat_en & force_video_mask;
        end else if (cs == IDLE && ns == CFG_UPDATE) begin
            if (pipe_quit) begin
                mask_map <= mask_map | loss_map;
            end else begin
                mask_map <= mask_map & ~recover_map;
            end
        end
    end

    // One cycle write mode publish
    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            wr_mode        <= {NUM_PIPES{WR_IDLE}};
            wr_mode_strobe <= '0;
        end else if (concat_mode && cs == CFG_UPDATE) begin
            for (int i = 0; i < NUM_PIPES; i++) begin
                if (!concat_en[i]) begin
                    wr_mode[i] <= WR_IDLE;
                end else if (mask_map[i]) begin
                    wr_mode[i] <= WR_MASKED;
                end else begin
                    wr_mode[i] <= WR_CONCAT;
                end
            end
            wr_mode_strobe <= concat_en;
        end else begin
            wr_mode        <= {NUM_PIPES{WR_IDLE}};
            wr_mode_strobe <= '0;
        end
    end

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            pipe_clear_bit_map <= '0;
        end else if (cs == CFG_UPDATE) begin
            pipe_clear_bit_map <= concat_en;
        end else begin
            pipe_clear_bit_map <= '0;
        end
    end

    // Data types of the ready pipes are only compared on round start
    assign start_cond = (cs == IDLE) && (ns == START_SCH);
    assign cmp_vld    = {NUM_PIPES{start_cond}} & pipe_rdy & dt_vld;

    data_type_compare #(
        .DT_WIDTH (DT_WIDTH)
    ) u_data_type_compare (
        .dt_vld  (cmp_vld),
        .dt      (dt),
        .dt_fail (dt_fail)
    );

    assign sch_start = start_cond & ~dt_fail;

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            sch_data_type_align_fail_int <= 1'b0;
        end else if (concat_mode) begin
            sch_data_type_align_fail_int <= dt_fail;
        end
    end

endmodule

// File: line_sched.sv
`timescale 1ns/1ns

module line_sched
    import aggre_cfg_pkg::*;
    import aggre_sch_pkg::*;
(
    input  logic                  aggre_clk,
    input  logic                  aggre_clk_rst_n,
    input  logic [NUM_PIPES-1:0]  concat_en,
    input  logic [NUM_PIPES-1:0]  ack,
    input  logic [NUM_PIPES-1:0]  line_end,
    input  logic [PIPE_IDX_W-1:0] master_pipe,
    input  logic                  sch_start,
    input  logic [NUM_PIPES-1:0]  pipe_rdy,
    output logic [NUM_PIPES-1:0]  up_state_concat,
    output logic [NUM_PIPES-1:0]  ack_concat,
    output logic [NUM_PIPES-1:0]  line_end_concat,
    output logic                  sch_end
);

    sch_state_t                            cs;
    sch_state_t                            ns;
    logic [NUM_PIPES-1:0]                  slot_vld;
    logic [NUM_PIPES-1:0][PIPE_IDX_W-1:0]  slot_pipe;
    logic [NUM_PIPES-1:0]                  rot_vld;
    logic [NUM_PIPES-1:0][PIPE_IDX_W-1:0]  rot_pipe;
    logic [PIPE_IDX_W-1:0]                 first_idx;
    logic                                  found;
    logic [PIPE_IDX_W-1:0]                 rot_idx;
    logic [PIPE_IDX_W-1:0]                 order;
    logic                                  master_first;
    logic                                  master_flag;
    logic                                  ack_seen;

    assign ack_concat      = concat_en & ack;
    assign line_end_concat = concat_en & line_end;

    assign ack_seen = (cs == WAIT_ACK) && (ns == CLEAR_STATE);

    // First valid slot
    always_comb begin
        first_idx = '0;
        found     = 1'b0;
        for (int i = 0; i < NUM_PIPES; i++) begin
            if (slot_vld[i] && !found) begin
                first_idx = PIPE_IDX_W'(i);
                found     = 1'b1;
            end
        end
    end

    assign order   = slot_pipe[first_idx];
    assign rot_idx = master_flag ? master_pipe : first_idx; // Master sits in its own slot

    // Served slot goes to the tail, the rest keep cyclic order after it
    always_comb begin
        for (int k = 0; k < NUM_PIPES - 1; k++) begin
            rot_vld[k]  = slot_vld[rot_idx + PIPE_IDX_W'(k + 1)];
            rot_pipe[k] = slot_pipe[rot_idx + PIPE_IDX_W'(k + 1)];
        end
        rot_vld[NUM_PIPES-1]  = 1'b0;
        rot_pipe[NUM_PIPES-1] = slot_pipe[rot_idx];
    end

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            slot_vld  <= '0;
            slot_pipe <= '0;
        end else if (sch_start) begin
            slot_vld <= pipe_rdy;
            for (int i = 0; i < NUM_PIPES; i++) begin
                slot_pipe[i] <= PIPE_IDX_W'(i);
            end
        end else if (ack_seen) begin
            slot_vld  <= rot_vld;
            slot_pipe <= rot_pipe;
        end
    end

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            master_first <= 1'b1;
        end else if (sch_start) begin
            master_first <= pipe_rdy[master_pipe];
        end
    end

    // Set while the master grant is out
    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            master_flag <= 1'b0;
        end else if (cs == MASTER) begin
            master_flag <= 1'b1;
        end else if (ack_seen) begin
            master_flag <= 1'b0;
        end
    end

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            cs <= SILENT;
        end else begin
            cs <= ns;
        end
    end

    always_comb begin
        ns = cs;
        case (cs)
            SILENT: begin
                if (sch_start) ns = START_CONCAT;
            end
            START_CONCAT: ns = master_first ? MASTER : ORDER;
            MASTER:       ns = WAIT_ACK;
            ORDER:        ns = WAIT_ACK;
            WAIT_ACK: begin
                if (|ack_concat) ns = CLEAR_STATE;
            end
            CLEAR_STATE:  ns = WAIT_LINE_END;
            WAIT_LINE_END: begin
                if (|line_end_concat) begin
                    ns = (|slot_vld) ? ORDER : SILENT;
                end
            end
            END_CONCAT:   ns = SILENT;
            default:      ns = SILENT;
        endcase
    end

    // Grants, one pipe at a time
    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            up_state_concat <= '0;
        end else begin
            for (int j = 0; j < NUM_PIPES; j++) begin
                if (ns == MASTER && master_pipe == PIPE_IDX_W'(j)) begin
                    up_state_concat[j] <= 1'b1;
                end else if (ns == ORDER && order == PIPE_IDX_W'(j)) begin
                    up_state_concat[j] <= 1'b1;
                end else if (ns == CLEAR_STATE && ack_concat[j]) begin
                    up_state_concat[j] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge aggre_clk or negedge aggre_clk_rst_n) begin
        if (!aggre_clk_rst_n) begin
            sch_end <= 1'b0;
        end else begin
            sch_end <= (cs == WAIT_LINE_END) && (ns == SILENT);
        end
    end

endmodule

// File: concat_line_top.sv
`timescale 1ns/1ns

module concat_line_top
    import aggre_cfg_pkg::*;
#(
    parameter int DT_WIDTH = DT_WIDTH_DEF
) (
    input  logic                               aggre_clk,
    input  logic                               aggre_clk_rst_n,
    input  aggre_mode_t                        aggre_mode,
    input  logic [NUM_PIPES-1:0]               concat_en,
    input  logic [NUM_PIPES-1:0]               video_loss,
    input  logic [NUM_PIPES-1:0]               empty,
    input  logic [NUM_PIPES-1:0]               ack,
    input  logic [NUM_PIPES-1:0]               line_end,
    input  logic                               frame_sync_lock,
    input  logic [PIPE_IDX_W-1:0]              master_pipe,
    input  logic [NUM_PIPES-1:0]               auto_mask_en,
    input  logic [NUM_PIPES-1:0]               force_video_mask,
    input  logic [NUM_PIPES-1:0]               video_mask_restart,
    input  logic [NUM_PIPES-1:0]               dt_vld,
    input  logic [NUM_PIPES-1:0][DT_WIDTH-1:0] dt,
    output logic [NUM_PIPES-1:0]               up_state_concat,
    output logic [NUM_PIPES-1:0]               ack_concat,
    output logic [NUM_PIPES-1:0]               line_end_concat,
    output wr_mode_t [NUM_PIPES-1:0]           wr_mode,
    output logic [NUM_PIPES-1:0]               wr_mode_strobe,
    output logic [NUM_PIPES-1:0]               pipe_clear_bit_map,
    output logic                               sch_data_type_align_fail_int
);

    logic                 sch_start; // Round start pulse
    logic                 sch_end;
    logic [NUM_PIPES-1:0] pipe_rdy;

    concat_cfg_ctrl #(
        .DT_WIDTH (DT_WIDTH)
    ) u_concat_cfg_ctrl (
        .aggre_clk                    (aggre_clk),
        .aggre_clk_rst_n              (aggre_clk_rst_n),
        .aggre_mode                   (aggre_mode),
        .concat_en                    (concat_en),
        .video_loss                   (video_loss),
        .empty                        (empty),
        .frame_sync_lock              (frame_sync_lock),
        .auto_mask_en                 (auto_mask_en),
        .force_video_mask             (force_video_mask),
        .video_mask_restart           (video_mask_restart),
        .dt_vld                       (dt_vld),
        .dt                           (dt),
        .sch_end                      (sch_end),
        .wr_mode                      (wr_mode),
        .wr_mode_strobe               (wr_mode_strobe),
        .pipe_clear_bit_map           (pipe_clear_bit_map),
        .sch_data_type_align_fail_int (sch_data_type_align_fail_int),
        .sch_start                    (sch_start),
        .pipe_rdy                     (pipe_rdy)
    );

    line_sched u_line_sched (
        .aggre_clk       (aggre_clk),
        .aggre_clk_rst_n (aggre_clk_rst_n),
        .concat_en       (concat_en),
        .ack             (ack),
        .line_end        (line_end),
        .master_pipe     (master_pipe),
        .sch_start       (sch_start),
        .pipe_rdy        (pipe_rdy),
        .up_state_concat (up_state_concat),
        .ack_concat      (ack_concat),
        .line_end_concat (line_end_concat),
        .sch_end         (sch_end)
    );

endmodule

// File: tb_concat_line.sv
`timescale 1ns/1ns

module tb_concat_line
    import aggre_cfg_pkg::*;
    import aggre_sch_pkg::*;
();

    localparam int DT_WIDTH    = DT_WIDTH_DEF;
    localparam int TIMEOUT     = 50;  // Cycles per wait
    localparam int NUM_ROWS    = 6;
    localparam int ACT_NONE    = 0;
    localparam int ACT_LOCK    = 1;
    localparam int ACT_LOSS    = 2;
    localparam int ACT_RESTART = 3;

    logic                               aggre_clk;
    logic                               aggre_clk_rst_n;
    aggre_mode_t                        aggre_mode;
    logic [NUM_PIPES-1:0]               concat_en;
    logic [NUM_PIPES-1:0]               video_loss;
    logic [NUM_PIPES-1:0]               empty;
    logic [NUM_PIPES-1:0]               ack;
    logic [NUM_PIPES-1:0]               line_end;
    logic                               frame_sync_lock;
    logic [PIPE_IDX_W-1:0]              master_pipe;
    logic [NUM_PIPES-1:0]               auto_mask_en;
    logic [NUM_PIPES-1:0]               force_video_mask;
    logic [NUM_PIPES-1:0]               video_mask_restart;
    logic [NUM_PIPES-1:0]               dt_vld;
    logic [NUM_PIPES-1:0][DT_WIDTH-1:0] dt;
    logic [NUM_PIPES-1:0]               up_state_concat;
    logic [NUM_PIPES-1:0]               ack_concat;
    logic [NUM_PIPES-1:0]               line_end_concat;
    wr_mode_t [NUM_PIPES-1:0]           wr_mode;
    logic [NUM_PIPES-1:0]               wr_mode_strobe;
    logic [NUM_PIPES-1:0]               pipe_clear_bit_map;
    logic                               sch_data_type_align_fail_int;

    int     err_cnt = 0;
    int     to_cnt  = 0;
    integer seed    = 32'hf2393a8f;
    int     exp_q[$]; // Expected grant order of the current row

    // Pipe 2 is disabled throughout, its data type differs on purpose
    string      row_name   [NUM_ROWS] = '{"lock_mask", "master_wrap", "restart_p3",
                                          "loss_p1", "restart_p1", "dt_mismatch"};
    int         row_act    [NUM_ROWS] = '{ACT_LOCK, ACT_NONE, ACT_RESTART,
                                          ACT_LOSS, ACT_RESTART, ACT_NONE};
    logic [1:0] row_apipe  [NUM_ROWS] = '{2'd0, 2'd0, 2'd3, 2'd1, 2'd1, 2'd0};
    logic [3:0] row_en     [NUM_ROWS] = '{4'b1011, 4'b1011, 4'b1011,
                                          4'b1011, 4'b1011, 4'b1011};
    logic [3:0] row_force  [NUM_ROWS] = '{4'b1000, 4'b1000, 4'b1000,
                                          4'b1000, 4'b1000, 4'b1000};
    logic [1:0] row_master [NUM_ROWS] = '{2'd0, 2'd1, 2'd3, 2'd3, 2'd0, 2'd0};
    logic [3:0] row_rdy    [NUM_ROWS] = '{4'b0011, 4'b0011, 4'b1011,
                                          4'b1001, 4'b1011, 4'b1011};
    logic [23:0] row_dt    [NUM_ROWS] = '{
        {6'h2A, 6'h3F, 6'h2A, 6'h2A}, {6'h2A, 6'h3F, 6'h2A, 6'h2A},
        {6'h2A, 6'h3F, 6'h2A, 6'h2A}, {6'h2A, 6'h3F, 6'h2A, 6'h2A},
        {6'h2A, 6'h3F, 6'h2A, 6'h2A}, {6'h2A, 6'h3F, 6'h15, 6'h2A}};
    logic [7:0] row_wr     [NUM_ROWS] = '{
        {WR_MASKED, WR_IDLE, WR_CONCAT, WR_CONCAT}, 8'hFF,
        {WR_CONCAT, WR_IDLE, WR_CONCAT, WR_CONCAT},
        {WR_CONCAT, WR_IDLE, WR_MASKED, WR_CONCAT},
        {WR_CONCAT, WR_IDLE, WR_CONCAT, WR_CONCAT}, 8'hFF};
    logic       row_fail   [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    logic [3:0] row_stray  [NUM_ROWS] = '{4'b0100, 4'b0, 4'b0, 4'b0, 4'b0, 4'b0};

    concat_line_top #(
        .DT_WIDTH (DT_WIDTH)
    ) dut (
        .aggre_clk                    (aggre_clk),
        .aggre_clk_rst_n              (aggre_clk_rst_n),
        .aggre_mode                   (aggre_mode),
        .concat_en                    (concat_en),
        .video_loss                   (video_loss),
        .empty                        (empty),
        .ack                          (ack),
        .line_end                     (line_end),
        .frame_sync_lock              (frame_sync_lock),
        .master_pipe                  (master_pipe),
        .auto_mask_en                 (auto_mask_en),
        .force_video_mask             (force_video_mask),
        .video_mask_restart           (video_mask_restart),
        .dt_vld                       (dt_vld),
        .dt                           (dt),
        .up_state_concat              (up_state_concat),
        .ack_concat                   (ack_concat),
        .line_end_concat              (line_end_concat),
        .wr_mode                      (wr_mode),
        .wr_mode_strobe               (wr_mode_strobe),
        .pipe_clear_bit_map           (pipe_clear_bit_map),
        .sch_data_type_align_fail_int (sch_data_type_align_fail_int)
    );

    initial begin
        aggre_clk = 1'b0;
        forever #50 aggre_clk = ~aggre_clk;
    end

    task automatic check_val(input string tname, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            err_cnt++;
            $display("ERROR %s: %s expected %0h actual %0h", tname, what, exp, act);
        end
    endtask

    // Master first if ready, then ascending cyclic order from the master
    function automatic void build_order(input logic [3:0] rdy, input logic [1:0] mp);
        logic [1:0] p;
        exp_q.delete();
        if (rdy[mp]) exp_q.push_back(int'(mp));
        for (int k = 1; k < NUM_PIPES; k++) begin
            p = mp + 2'(k);
            if (rdy[p]) exp_q.push_back(int'(p));
        end
    endfunction

    task automatic wait_grant(input string tname, output logic [3:0] g, output bit ok);
        int cnt;
        cnt = 0;
        @(negedge aggre_clk);
        while (up_state_concat == '0 && cnt < TIMEOUT) begin
            @(negedge aggre_clk);
            cnt++;
        end
        g  = up_state_concat;
        ok = (g != '0);
        if (!ok) begin
            to_cnt++;
            $display("Timeout in %s: no grant came from the scheduler", tname);
        end
    endtask

    task automatic wait_cfg_idle(input string tname);
        int cnt;
        cnt = 0;
        @(negedge aggre_clk);
        while (dut.u_concat_cfg_ctrl.cs != IDLE && cnt < TIMEOUT) begin
            @(negedge aggre_clk);
            cnt++;
        end
        if (dut.u_concat_cfg_ctrl.cs != IDLE) begin
            to_cnt++;
            $display("Timeout in %s: configuration FSM did not return to IDLE", tname);
        end
    endtask

    task automatic check_strobe(input int i);
        int cnt;
        cnt = 0;
        @(negedge aggre_clk);
        while (wr_mode_strobe == '0 && cnt < TIMEOUT) begin
            @(negedge aggre_clk);
            cnt++;
        end
        if (wr_mode_strobe == '0) begin
            to_cnt++;
            $display("Timeout in %s: write mode strobe never came", row_name[i]);
        end else begin
            check_val(row_name[i], "wr_mode_strobe", row_en[i], wr_mode_strobe);
            check_val(row_name[i], "pipe_clear_bit_map", row_en[i], pipe_clear_bit_map);
            check_val(row_name[i], "wr_mode", row_wr[i], wr_mode);
            @(negedge aggre_clk); // One cycle only
            check_val(row_name[i], "strobe after publish", 0, wr_mode_strobe);
            check_val(row_name[i], "wr_mode after publish", 8'hFF, wr_mode);
            check_val(row_name[i], "clear map after publish", 0, pipe_clear_bit_map);
        end
    endtask

    task automatic serve_round(input int i);
        logic [3:0] g;
        logic [3:0] stray;
        bit         ok;
        int         d;
        build_order(row_rdy[i], row_master[i]);
        for (int k = 0; k < exp_q.size(); k++) begin
            wait_grant(row_name[i], g, ok);
            if (!ok) return;
            check_val(row_name[i], "grant", 32'd1 << exp_q[k], g);
            if (k == 0) check_val(row_name[i], "alignment interrupt", 0,
                                  sch_data_type_align_fail_int);
            stray = (k == 0) ? row_stray[i] : 4'b0;
            d     = 1 + ($unsigned($random(seed)) % 4);
            @(posedge aggre_clk);
            if (k == 0) empty <= '1; // Round is latched, keep the next one off
            repeat (d - 1) @(posedge aggre_clk);
            if (stray != '0) begin
                ack <= stray;
                @(negedge aggre_clk);
                check_val(row_name[i], "ack_concat on disabled pipe", 0, ack_concat);
                @(posedge aggre_clk);
                ack <= '0;
                @(negedge aggre_clk);
                check_val(row_name[i], "grant held after stray ack", g, up_state_concat);
                @(posedge aggre_clk);
            end
            ack <= g;
            @(negedge aggre_clk);
            check_val(row_name[i], "ack_concat", 32'd1 << exp_q[k], ack_concat);
            @(posedge aggre_clk);
            ack <= '0;
            @(negedge aggre_clk);
            check_val(row_name[i], "grant after ack", 0, up_state_concat);
            @(posedge aggre_clk);
            if (stray != '0) begin
                line_end <= stray;
                @(negedge aggre_clk);
                check_val(row_name[i], "line_end_concat on disabled pipe", 0,
                          line_end_concat);
                @(posedge aggre_clk);
                line_end <= g;
                @(negedge aggre_clk);
                check_val(row_name[i], "grant after stray line end", 0, up_state_concat);
                check_val(row_name[i], "line_end_concat", 32'd1 << exp_q[k],
                          line_end_concat);
                @(posedge aggre_clk);
            end else begin
                line_end <= g;
                @(negedge aggre_clk);
                check_val(row_name[i], "line_end_concat", 32'd1 << exp_q[k],
                          line_end_concat);
                @(posedge aggre_clk);
            end
            line_end <= '0;
        end
        wait_cfg_idle(row_name[i]);
        check_val(row_name[i], "grant after round", 0, up_state_concat);
    endtask

    task automatic check_align_fail(input int i);
        int cnt;
        cnt = 0;
        @(negedge aggre_clk);
        while (!sch_data_type_align_fail_int && cnt < TIMEOUT) begin
            @(negedge aggre_clk);
            cnt++;
        end
        if (!sch_data_type_align_fail_int) begin
            to_cnt++;
            $display("Timeout in %s: alignment interrupt never rose", row_name[i]);
        end else begin
            @(negedge aggre_clk);
            check_val(row_name[i], "interrupt one cycle later", 0,
                      sch_data_type_align_fail_int);
        end
        cnt = 0;
        while (up_state_concat == '0 && cnt < TIMEOUT) begin
            @(negedge aggre_clk);
            cnt++;
        end
        check_val(row_name[i], "grant after mismatch", 0, up_state_concat);
    endtask

    task automatic run_row(input int i);
        @(posedge aggre_clk);
        concat_en        <= row_en[i];
        force_video_mask <= row_force[i];
        master_pipe      <= row_master[i];
        dt               <= row_dt[i];
        dt_vld           <= '1;
        empty            <= '1;
        if (row_act[i] == ACT_LOCK) begin
            aggre_mode      <= AGGRE_CONCAT;
            frame_sync_lock <= 1'b1;
        end else if (row_act[i] == ACT_LOSS || row_act[i] == ACT_RESTART) begin
            @(posedge aggre_clk);
            if (row_act[i] == ACT_LOSS) video_loss <= 4'b1 << row_apipe[i];
            else video_mask_restart <= 4'b1 << row_apipe[i];
            @(posedge aggre_clk);
            video_loss         <= '0;
            video_mask_restart <= '0;
        end
        if (row_act[i] != ACT_NONE) check_strobe(i);
        @(posedge aggre_clk);
        empty <= ~row_rdy[i];
        if (row_fail[i]) check_align_fail(i);
        else serve_round(i);
    endtask

    initial begin
        aggre_clk_rst_n    = 1'b0;
        aggre_mode         = AGGRE_NONE;
        concat_en          = '0;
        video_loss         = '0;
        empty              = '1;
        ack                = '0;
        line_end           = '0;
        frame_sync_lock    = 1'b0;
        master_pipe        = '0;
        auto_mask_en       = '1;
        force_video_mask   = '0;
        video_mask_restart = '0;
        dt_vld             = '0;
        dt                 = '0;
        repeat (2) @(posedge aggre_clk);
        aggre_clk_rst_n <= 1'b1;
        @(negedge aggre_clk);
        check_val("reset", "up_state_concat", 0, up_state_concat);
        check_val("reset", "wr_mode_strobe", 0, wr_mode_strobe);
        check_val("reset", "pipe_clear_bit_map", 0, pipe_clear_bit_map);
        check_val("reset", "alignment interrupt", 0, sch_data_type_align_fail_int);
        check_val("reset", "wr_mode", 8'hFF, wr_mode);
        // Mismatch row is last, the controller stalls after it
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("errors=%0d timeouts=%0d", err_cnt, to_cnt);
        if (err_cnt == 0 && to_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
aggre_cfg_pkg.sv
aggre_sch_pkg.sv
data_type_compare.sv
concat_cfg_ctrl.sv
line_sched.sv
concat_line_top.sv
tb_concat_line.sv
